//--- hdl/ipv6_tx_pkg.sv
//////////////////////////////////////////////////////////////////////
// Shared types, metadata struct, state and field enums and protocol
// constants for the IPv6/UDP frame transmitter
//////////////////////////////////////////////////////////////////////
package ipv6_tx_pkg;

  typedef logic [47:0]  mac_t;
  typedef logic [127:0] ip_t;
  typedef logic [63:0]  iid_t;
  typedef logic [63:0]  pfx_t;

  typedef enum logic {
    src_link_local,
    src_global
  } src_sel_e;

  // Per-packet metadata, captured on send
  typedef struct packed {
    mac_t        dst_mac;
    ip_t         dst_ip;
    logic [7:0]  tclass;   // Traffic class
    logic [19:0] flow;
    logic [7:0]  hop_lim;
    logic [15:0] src_port;
    logic [15:0] dst_port;
    logic [15:0] pld_len;  // UDP payload bytes
    logic [15:0] pld_cks;  // Ones'-complement sum of payload
    src_sel_e    src_sel;
  } tx_meta_t;

  typedef enum logic [3:0] {
    idle_s,
    pre_s,
    eth_s,
    ip_hdr_s,
    ip_src_s,
    ip_dst_s,
    pseudo_s,
    udp_s,
    pld_s,
    fcs_s,
    gap_s
  } tx_state_e;

  // Which header image the shifter loads
  typedef enum logic [2:0] {
    fld_none,
    fld_pre,
    fld_eth,
    fld_ip_hdr,
    fld_ip_src,
    fld_ip_dst,
    fld_pseudo,
    fld_udp
  } tx_field_e;

  //////////////////////////////////////////////////////////////////////
  // Field lengths in bytes
  //////////////////////////////////////////////////////////////////////
  localparam int PREAMBLE_LEN    = 8;
  localparam int ETH_HDR_LEN     = 14;
  localparam int IP_HDR_LEN      = 40;
  localparam int IP_FIXED_LEN    = IP_HDR_LEN - 2 * ($bits(ip_t) / 8);
  localparam int PSEUDO_TAIL_LEN = 8;
  localparam int UDP_HDR_LEN     = 8;
  localparam int FCS_LEN         = 4;
  localparam int PISO_BYTES      = 16; // Widest field, an IPv6 address

  localparam logic [15:0] ETHERTYPE_IPV6 = 16'h86DD;
  localparam logic [7:0]  IP_PROTO_UDP   = 8'd17;
  localparam pfx_t        LINK_LOCAL_PFX = 64'hfe80_0000_0000_0000;
  localparam logic [63:0] PREAMBLE_SFD   = 64'h5555_5555_5555_55D5;

endpackage

//--- hdl/inet_cks.sv
//////////////////////////////////////////////////////////////////////
// Internet checksum, bytewise ones'-complement accumulator
//////////////////////////////////////////////////////////////////////
module inet_cks (
  input  logic        clk,
  input  logic        init,
  input  logic [15:0] seed,
  input  logic [7:0]  dat,
  input  logic        en,
  output logic [15:0] cks
);

  logic [15:0] sum;
  logic        hi;    // Next byte is the high half of a word
  logic [16:0] add;

  assign add = {1'b0, sum} + (hi ? {1'b0, dat, 8'h00} : {9'h000, dat});

  always_ff @(posedge clk) begin
    if (init) begin
      sum <= seed;
      hi  <= 1'b1;
    end else if (en) begin
      sum <= add[15:0] + {15'h0000, add[16]}; // End-around carry
      hi  <= !hi;
    end
  end

  // A computed zero goes out as all ones
  assign cks = (sum == 16'hFFFF) ? 16'hFFFF : ~sum;

endmodule

//--- hdl/eth_crc32.sv
//////////////////////////////////////////////////////////////////////
// Ethernet FCS generator, reflected CRC-32 one byte per cycle
//////////////////////////////////////////////////////////////////////
module eth_crc32 (
  input  logic        clk,
  input  logic        init,
  input  logic [7:0]  dat,
  input  logic        en,
  output logic [31:0] crc
);

  localparam logic [31:0] POLY_REV = 32'hEDB8_8320; // 04C11DB7 bit reversed

  function automatic logic [31:0] crc_byte(input logic [31:0] c, input logic [7:0] d);
    logic [31:0] r;
    r = c ^ {24'h000000, d};
    for (int i = 0; i < 8; i++) begin
      if (r[0]) r = (r >> 1) ^ POLY_REV;
      else r = r >> 1;
    end
    return r;
  endfunction

  always_ff @(posedge clk) begin
    if (init) crc <= '1;
    else if (en) crc <= crc_byte(crc, dat);
  end

endmodule

//--- hdl/tx_field_piso.sv
//////////////////////////////////////////////////////////////////////
// Header field builder and byte shifter with payload and FCS mux
//////////////////////////////////////////////////////////////////////
module tx_field_piso
  import ipv6_tx_pkg::*;
#(
  parameter mac_t MAC_ADDR = 48'h02_00_00_00_00_01
) (
  input  logic        clk,
  input  tx_field_e   field,
  input  logic        load,
  input  logic        shift,
  input  logic        pld_sel,
  input  logic        fcs_sel,
  input  logic        cks_ready,
  input  tx_meta_t    meta_q,
  input  iid_t        iid,
  input  pfx_t        pfx,
  input  logic [15:0] cks,
  input  logic [31:0] crc,
  input  logic [7:0]  pld_dat,
  output logic [7:0]  dat
);

  logic [PISO_BYTES-1:0][7:0]     img;    // Field image, first byte at top
  logic [PISO_BYTES-1:0][7:0]     sr;
  logic [15:0]                    ip_pld_len;
  ip_t                            src_ip;
  logic [15:0]                    udp_cks;
  logic [$clog2(FCS_LEN)-1:0]     fcs_idx;

  assign ip_pld_len = 16'(UDP_HDR_LEN) + meta_q.pld_len; // Also the UDP length
  assign udp_cks    = cks_ready ? cks : 16'h0000;

  always_comb begin
    if (meta_q.src_sel == src_link_local) src_ip = {LINK_LOCAL_PFX, iid};
    else src_ip = {pfx, iid};
  end

  //////////////////////////////////////////////////////////////////////
  // Byte images in network order, zero padded at the tail
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    case (field)
      fld_pre    : img = {PREAMBLE_SFD, 64'h0};
      fld_eth    : img = {meta_q.dst_mac, MAC_ADDR, ETHERTYPE_IPV6, 16'h0};
      fld_ip_hdr : img = {4'd6, meta_q.tclass, meta_q.flow, ip_pld_len,
                          IP_PROTO_UDP, meta_q.hop_lim, 64'h0};
      fld_ip_src : img = src_ip;
      fld_ip_dst : img = meta_q.dst_ip;
      // Upper-layer length and next header
      fld_pseudo : img = {16'h0, ip_pld_len, 24'h0, IP_PROTO_UDP, 64'h0};
      fld_udp    : img = {meta_q.src_port, meta_q.dst_port, ip_pld_len, udp_cks, 64'h0};
      default    : img = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (load) sr <= img;
    else if (shift) sr <= {sr[PISO_BYTES-2:0], 8'h00};
  end

  // FCS goes out low byte first
  always_ff @(posedge clk) begin
    if (fcs_sel) fcs_idx <= fcs_idx + 1'b1;
    else fcs_idx <= '0;
  end

  always_comb begin
    if (fcs_sel) dat = ~crc[8*fcs_idx +: 8];
    else if (pld_sel) dat = pld_dat;
    else dat = sr[PISO_BYTES-1];
  end

endmodule

//--- hdl/tx_seq.sv
//////////////////////////////////////////////////////////////////////
// Transmit sequencer: metadata register, two-pass FSM, field counter
//////////////////////////////////////////////////////////////////////
module tx_seq
  import ipv6_tx_pkg::*;
#(
  parameter int IFG_LEN     = 12,
  parameter int MAX_PLD_LEN = 1232
) (
  input  logic      clk,
  input  logic      rst,
  input  logic      send,
  input  tx_meta_t  meta,
  output tx_meta_t  meta_q,
  output tx_field_e field,
  output logic      load,
  output logic      shift,
  output logic      pld_sel,
  output logic      fcs_sel,
  output logic      cks_init,
  output logic      cks_en,
  output logic      cks_ready,
  output logic      crc_init,
  output logic      crc_en,
  output logic      pld_req,
  output logic      busy,
  output logic      done,
  output logic      phy_val
);

  localparam int CNT_MAX = (MAX_PLD_LEN > IFG_LEN + 1) ? MAX_PLD_LEN : IFG_LEN + 1;
  localparam int CNT_W   = $clog2(((CNT_MAX > PISO_BYTES) ? CNT_MAX : PISO_BYTES) + 1);

  tx_state_e        state;
  logic [CNT_W-1:0] cnt;
  logic [CNT_W-1:0] len;     // Bytes or cycles in current state
  logic             last;
  logic             accept;
  logic             start;
  logic             tx_now;
  logic             crc_now;
  logic             cks_now;

  assign busy   = (state != idle_s);
  assign accept = send && !busy;

  always_ff @(posedge clk) begin
    if (accept) meta_q <= meta;
  end

  always_comb begin
    case (state)
      pre_s              : len = CNT_W'(PREAMBLE_LEN);
      eth_s              : len = CNT_W'(ETH_HDR_LEN);
      ip_hdr_s           : len = CNT_W'(IP_FIXED_LEN);
      ip_src_s, ip_dst_s : len = CNT_W'($bits(ip_t) / 8);
      pseudo_s           : len = CNT_W'(PSEUDO_TAIL_LEN);
      udp_s              : len = CNT_W'(UDP_HDR_LEN);
      pld_s              : len = CNT_W'(meta_q.pld_len);
      fcs_s              : len = CNT_W'(FCS_LEN);
      gap_s              : len = CNT_W'(IFG_LEN + 1); // Last FCS byte leaves in first gap cycle
      default            : len = CNT_W'(1);
    endcase
  end

  assign last = (cnt == len - CNT_W'(1));

  always_comb begin
    case (state)
      pre_s    : field = fld_pre;
      eth_s    : field = fld_eth;
      ip_hdr_s : field = fld_ip_hdr;
      ip_src_s : field = fld_ip_src;
      ip_dst_s : field = fld_ip_dst;
      pseudo_s : field = fld_pseudo;
      udp_s    : field = fld_udp;
      default  : field = fld_none;
    endcase
  end

  assign load  = (field != fld_none) && (cnt == '0); // New image on first byte
  assign shift = busy && !load;

  //////////////////////////////////////////////////////////////////////
  // State machine
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= idle_s;
      cnt       <= '0;
      cks_ready <= 1'b0;
    end else begin
      if (!busy || last) cnt <= '0;
      else cnt <= cnt + CNT_W'(1);
      case (state)
        idle_s : if (accept) begin
          state     <= ip_src_s; // Checksum pass skips preamble and Ethernet
          cks_ready <= 1'b0;
        end
        pre_s    : if (last) state <= eth_s;
        eth_s    : if (last) state <= ip_hdr_s;
        ip_hdr_s : if (last) state <= ip_src_s;
        ip_src_s : if (last) state <= ip_dst_s;
        ip_dst_s : if (last) state <= cks_ready ? udp_s : pseudo_s;
        pseudo_s : if (last) state <= udp_s;
        udp_s    : if (last) begin
          if (!cks_ready) begin
            state     <= pre_s;
            cks_ready <= 1'b1;
          end else if (meta_q.pld_len == 16'd0) begin
            state <= fcs_s;
          end else begin
            state <= pld_s;
          end
        end
        pld_s    : if (last) state <= fcs_s;
        fcs_s    : if (last) state <= gap_s;
        gap_s    : if (last) state <= idle_s;
        default  : state <= idle_s;
      endcase
    end
  end

  // Byte qualifiers, one cycle ahead of the shifter head
  always_comb begin
    tx_now  = cks_ready && (state inside {pre_s, eth_s, ip_hdr_s, ip_src_s,
                                          ip_dst_s, udp_s, pld_s, fcs_s});
    crc_now = cks_ready && (state inside {eth_s, ip_hdr_s, ip_src_s, ip_dst_s,
                                          udp_s, pld_s});
    cks_now = !cks_ready && (state inside {ip_src_s, ip_dst_s, pseudo_s, udp_s});
  end

  assign pld_req = (state == pld_s);

  always_ff @(posedge clk) begin
    if (rst) begin
      phy_val <= 1'b0;
      crc_en  <= 1'b0;
      cks_en  <= 1'b0;
      pld_sel <= 1'b0;
      fcs_sel <= 1'b0;
      start   <= 1'b0;
      done    <= 1'b0;
    end else begin
      phy_val <= tx_now;
      crc_en  <= crc_now;
      cks_en  <= cks_now;
      pld_sel <= (state == pld_s);
      fcs_sel <= (state == fcs_s);
      start   <= accept; // meta_q is valid from here
      done    <= (state == gap_s) && last;
    end
  end

  assign cks_init = start;
  assign crc_init = start;

endmodule

//--- hdl/ipv6_tx.sv
//////////////////////////////////////////////////////////////////////
// IPv6/UDP frame transmitter top level
//////////////////////////////////////////////////////////////////////
module ipv6_tx
  import ipv6_tx_pkg::*;
#(
  parameter mac_t MAC_ADDR    = 48'h02_00_00_00_00_01,
  parameter int   IFG_LEN     = 12,
  parameter int   MAX_PLD_LEN = 1232
) (
  input  logic       clk,
  input  logic       rst,
  input  iid_t       iid,
  input  pfx_t       pfx,
  input  logic       send,    // Start strobe, ignored while busy
  input  tx_meta_t   meta,
  output logic       busy,
  output logic       done,
  output logic       pld_req, // Byte expected on pld_dat next cycle
  input  logic [7:0] pld_dat,
  output logic [7:0] phy_dat,
  output logic       phy_val
);

  tx_meta_t    meta_q;
  tx_field_e   field;
  logic        load;
  logic        shift;
  logic        pld_sel;
  logic        fcs_sel;
  logic        cks_init;
  logic        cks_en;
  logic        cks_ready;
  logic        crc_init;
  logic        crc_en;
  logic [15:0] cks;
  logic [31:0] crc;

  tx_seq #(
    .IFG_LEN     (IFG_LEN),
    .MAX_PLD_LEN (MAX_PLD_LEN)
  ) i_seq (
    .clk       (clk),
    .rst       (rst),
    .send      (send),
    .meta      (meta),
    .meta_q    (meta_q),
    .field     (field),
    .load      (load),
    .shift     (shift),
    .pld_sel   (pld_sel),
    .fcs_sel   (fcs_sel),
    .cks_init  (cks_init),
    .cks_en    (cks_en),
    .cks_ready (cks_ready),
    .crc_init  (crc_init),
    .crc_en    (crc_en),
    .pld_req   (pld_req),
    .busy      (busy),
    .done      (done),
    .phy_val   (phy_val)
  );

  tx_field_piso #(
    .MAC_ADDR (MAC_ADDR)
  ) i_piso (
    .clk       (clk),
    .field     (field),
    .load      (load),
    .shift     (shift),
    .pld_sel   (pld_sel),
    .fcs_sel   (fcs_sel),
    .cks_ready (cks_ready),
    .meta_q    (meta_q),
    .iid       (iid),
    .pfx       (pfx),
    .cks       (cks),
    .crc       (crc),
    .pld_dat   (pld_dat),
    .dat       (phy_dat)
  );

  // Seeded from the caller's payload sum
  inet_cks i_cks (
    .clk  (clk),
    .init (cks_init),
    .seed (meta_q.pld_cks),
    .dat  (phy_dat),
    .en   (cks_en),
    .cks  (cks)
  );

  eth_crc32 i_crc (
    .clk  (clk),
    .init (crc_init),
    .dat  (phy_dat),
    .en   (crc_en),
    .crc  (crc)
  );

endmodule

//--- bench/tb_ipv6_tx.sv
//////////////////////////////////////////////////////////////////////
// IPv6/UDP transmitter testbench with stimulus file reader, payload
// source, frame capture and header, checksum, FCS and handshake checks
//////////////////////////////////////////////////////////////////////
module tb_ipv6_tx
  import ipv6_tx_pkg::*;
();

  localparam mac_t SRC_MAC     = 48'h02_5e_10_20_30_40;
  localparam iid_t IID         = 64'h0211_22ff_fe33_4455;
  localparam pfx_t PFX         = 64'h2001_0db8_0042_0007;
  localparam int   IFG         = 12;
  localparam int   MAX_PKTS    = 32;
  localparam int   MAX_BYTES   = 1600;
  localparam int   RST_CYCLES  = 16;
  localparam int   IDLE_CYCLES = 40;

  logic       clk;
  logic       rst;
  logic       send;
  tx_meta_t   meta;
  logic       busy;
  logic       done;
  logic       pld_req;
  logic [7:0] pld_dat;
  logic [7:0] phy_dat;
  logic       phy_val;

  tx_meta_t   pkt_meta [MAX_PKTS];
  int         frame_len [MAX_PKTS];
  int         seed_off [MAX_PKTS];
  int         n_pkts;
  logic [7:0] pld_buf [MAX_BYTES];  // Bytes handed to the DUT
  logic [7:0] cap [MAX_BYTES];      // Bytes seen on the PHY side
  int         cap_len;
  int         pld_idx;
  int         req_cnt;
  int         frames;
  int         dones;
  logic       in_pkt;
  logic       val_q;
  logic       req_q;
  int         cycles;
  int         cycle_limit;

  ipv6_tx #(
    .MAC_ADDR    (SRC_MAC),
    .IFG_LEN     (IFG),
    .MAX_PLD_LEN (1232)
  ) i_dut (
    .clk     (clk),
    .rst     (rst),
    .iid     (IID),
    .pfx     (PFX),
    .send    (send),
    .meta    (meta),
    .busy    (busy),
    .done    (done),
    .pld_req (pld_req),
    .pld_dat (pld_dat),
    .phy_dat (phy_dat),
    .phy_val (phy_val)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic fail_stop();
    $display("CHECKS FAILED");
    $fatal(1, "Stopping at first error");
  endtask

  task automatic check(input string what, input logic [127:0] got, input logic [127:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s, got %0h expected %0h", $time, what, got, exp);
      fail_stop();
    end
  endtask

  // Big-endian value of n captured bytes from pos
  function automatic logic [127:0] field_at(input int pos, input int n);
    logic [127:0] v;
    v = '0;
    for (int i = 0; i < n; i++) v = {v[119:0], cap[pos + i]};
    return v;
  endfunction

  function automatic logic [15:0] fold(input logic [31:0] s);
    logic [31:0] t;
    t = s;
    while (t[31:16] != 16'h0000) t = t[15:0] + t[31:16];
    return t[15:0];
  endfunction

  // MSB-first CRC-32, bits taken in wire order (LSB of each byte first)
  function automatic logic [31:0] crc_step(input logic [31:0] c, input logic [7:0] d);
    logic [31:0] r;
    logic        fb;
    r = c;
    for (int i = 0; i < 8; i++) begin
      fb = r[31] ^ d[i];
      r  = {r[30:0], 1'b0};
      if (fb) r = r ^ 32'h04C1_1DB7;
    end
    return r;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Stimulus file
  //////////////////////////////////////////////////////////////////////
  task automatic load_stim();
    int               fd;
    int               n;
    logic [8*160-1:0] text;
    logic [31:0]      sel;
    mac_t             dmac;
    ip_t              dip;
    logic [31:0]      tc;
    logic [31:0]      flow;
    logic [31:0]      hop;
    logic [31:0]      sport;
    logic [31:0]      dport;
    logic [31:0]      off;
    int               len;
    int               flen;
    tx_meta_t         m;
    fd = $fopen("bench/tx_stim.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the stimulus file bench/tx_stim.txt");
      fail_stop();
    end
    n_pkts = 0;
    while ($fgets(text, fd) != 0) begin
      n = $sscanf(text, "%h %h %h %h %h %h %h %h %d %h %d", sel, dmac, dip, tc, flow,
                  hop, sport, dport, len, off, flen);
      if (n == 11 && n_pkts < MAX_PKTS) begin
        m          = '0;
        m.dst_mac  = dmac;
        m.dst_ip   = dip;
        m.tclass   = tc[7:0];
        m.flow     = flow[19:0];
        m.hop_lim  = hop[7:0];
        m.src_port = sport[15:0];
        m.dst_port = dport[15:0];
        m.pld_len  = 16'(len);
        m.src_sel  = src_sel_e'(sel[0]);
        pkt_meta[n_pkts]  = m;
        seed_off[n_pkts]  = int'(off);
        frame_len[n_pkts] = flen;
        n_pkts++;
      end else if (n > 0) begin
        $display("Stimulus line is malformed or the packet table is full");
        fail_stop();
      end
    end
    $fclose(fd);
    if (n_pkts == 0) begin
      $display("The stimulus file holds no packets");
      fail_stop();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Drive one packet, then a stray send while busy
  //////////////////////////////////////////////////////////////////////
  task automatic send_packet(input int p);
    tx_meta_t    m;
    int          seed;
    logic [31:0] sum;
    m    = pkt_meta[p];
    seed = 32'h9173_fae1 + seed_off[p];
    sum  = '0;
    for (int i = 0; i < int'(m.pld_len); i++) begin
      pld_buf[i] = 8'($random(seed));
      sum += (i % 2 == 0) ? {16'h0, pld_buf[i], 8'h00} : {24'h0, pld_buf[i]};
    end
    m.pld_cks   = fold(sum);  // Odd tail counts as a padded high byte
    pkt_meta[p] = m;
    cap_len = 0;
    req_cnt = 0;
    pld_idx = 0;
    @(posedge clk);
    #1;
    send = 1'b1;
    meta = m;
    @(posedge clk);
    #1;
    send   = 1'b0;
    in_pkt = 1'b1;
    while (cap_len == 0) @(posedge clk);
    #1;
    send = 1'b1;            // Must be ignored
    meta = ~m;
    @(posedge clk);
    #1;
    send = 1'b0;
    while (in_pkt) @(posedge clk);
  endtask

  task automatic check_frame(input int p);
    tx_meta_t     m;
    int           len;
    logic [127:0] w;
    ip_t          src;
    logic [31:0]  sum;
    logic [31:0]  crc;
    m   = pkt_meta[p];
    len = int'(m.pld_len);
    check("frame length", cap_len, 74 + len);
    check("frame length against file", cap_len, frame_len[p]);
    check("frame count", frames, p + 1);
    check("done pulses", dones, p + 1);
    check("payload requests", req_cnt, len);
    for (int i = 0; i < 7; i++) check("preamble byte", cap[i], 8'h55);
    check("start of frame delimiter", cap[7], 8'hD5);
    check("destination MAC", field_at(8, 6), m.dst_mac);
    check("source MAC", field_at(14, 6), SRC_MAC);
    check("ethertype", field_at(20, 2), 16'h86DD);
    w = field_at(22, 4);
    check("IP version", w[31:28], 4'd6);
    check("traffic class", w[27:20], m.tclass);
    check("flow label", w[19:0], m.flow);
    check("IP payload length", field_at(26, 2), 8 + len);
    check("next header", cap[28], 8'd17);
    check("hop limit", cap[29], m.hop_lim);
    if (m.src_sel == src_link_local) src = {64'hfe80_0000_0000_0000, IID};
    else src = {PFX, IID};
    check("source IP", field_at(30, 16), src);
    check("destination IP", field_at(46, 16), m.dst_ip);
    check("UDP source port", field_at(62, 2), m.src_port);
    check("UDP destination port", field_at(64, 2), m.dst_port);
    check("UDP length", field_at(66, 2), 8 + len);
    for (int i = 0; i < len; i++) check("payload byte", cap[70 + i], pld_buf[i]);
    // Pseudo-header, UDP header and payload must sum to all ones
    sum = 32'(field_at(66, 2)) + 32'(cap[28]);
    for (int i = 0; i < 32; i += 2) sum += 32'(field_at(30 + i, 2));
    for (int i = 0; i < 8 + len; i++) begin
      sum += (i % 2 == 0) ? {16'h0, cap[62 + i], 8'h00} : {24'h0, cap[62 + i]};
    end
    check("UDP checksum sum", fold(sum), 16'hFFFF);
    crc = '1;
    for (int i = 8; i < cap_len; i++) crc = crc_step(crc, cap[i]);
    check("FCS residual", crc, 32'hC704_DD7B);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Payload source, monitor and timeout
  //////////////////////////////////////////////////////////////////////
  always @(posedge clk) begin
    #1;
    if (req_q) begin        // Byte due one cycle after the request
      pld_dat = pld_buf[pld_idx];
      pld_idx++;
    end
  end

  always @(negedge clk) begin
    if (!rst) begin
      if (phy_val && !val_q) frames++;
      if (phy_val) begin
        if (cap_len < MAX_BYTES) cap[cap_len] = phy_dat;
        cap_len++;
      end
      if (pld_req) req_cnt++;
      if (done) dones++;
      if (in_pkt && done) begin
        check("busy falls with done", busy, 1'b0);
        in_pkt = 1'b0;
      end else if (in_pkt) begin
        check("busy held until done", busy, 1'b1);
      end
    end
    val_q = phy_val;
    req_q = pld_req;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Timeout after %0d cycles, the DUT did not finish its frames", cycles);
      fail_stop();
    end
  end

  initial begin
    rst     = 1'b1;
    send    = 1'b0;
    meta    = '0;
    pld_dat = 8'h00;
    cap_len = 0;
    pld_idx = 0;
    req_cnt = 0;
    frames  = 0;
    dones   = 0;
    in_pkt  = 1'b0;
    val_q   = 1'b0;
    req_q   = 1'b0;
    cycles  = 0;
    load_stim();
    cycle_limit = RST_CYCLES + IDLE_CYCLES;
    for (int p = 0; p < n_pkts; p++) cycle_limit += frame_len[p] + 100;
    repeat (RST_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    check("busy after reset", busy, 1'b0);
    check("done after reset", done, 1'b0);
    check("phy_val after reset", phy_val, 1'b0);
    check("pld_req after reset", pld_req, 1'b0);
    for (int p = 0; p < n_pkts; p++) begin
      send_packet(p);
      check_frame(p);
    end
    repeat (IDLE_CYCLES) @(posedge clk);
    check("frames after the last packet", frames, n_pkts);
    check("done pulses after the last packet", dones, n_pkts);
    check("busy when idle", busy, 1'b0);
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

//--- bench/tx_stim.txt
// sel dst_mac dst_ip tclass flow hop sport dport pld_len seed_off frame_len
// sel 0 link-local 1 global, pld_len and frame_len decimal, others hex
0 333300000001 ff020000000000000000000000000001 00 00000 ff 1f40 1f41 0 00 74
1 0a1b2c3d4e5f 20010db8000000420000000000000007 2e 12345 40 c350 0035 1 01 75
0 02aabbccddee fe80000000000000021122fffe334466 00 fffff 01 04d2 162e 2 02 76
1 5254001a2b3c 20010db8abcd00010000000000000abc b8 0abcd 80 8000 ffff 17 03 91
0 3333ff334455 ff0200000000000000000001ff334455 e0 00001 ff 0222 0223 64 04 138
1 001122334455 2a00145040070808000000000000200e 04 54321 3f 9c40 01bb 255 05 329
1 66778899aabb 20010db8ffff0000fedcba9876543210 ff 80000 02 abcd dcba 512 06 586
0 0ab0cd0ef012 fe8000000000000012345678abcdef01 a0 3c3c3 10 0001 fffe 1232 07 1306

//--- compile.f
hdl/ipv6_tx_pkg.sv
hdl/inet_cks.sv
hdl/eth_crc32.sv
hdl/tx_field_piso.sv
hdl/tx_seq.sv
hdl/ipv6_tx.sv
bench/tb_ipv6_tx.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_ipv6_tx -f compile.f -o tb_ipv6_tx \
  > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/tb_ipv6_tx > sim.log 2>&1
grep -q "CHECKS FAILED" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "ALL CHECKS PASSED" sim.log || { echo "Simulation did not complete, see sim.log"; exit 1; }
echo "Simulation passed"
